// ==== compile.f ====
+incdir+dv
hdl/cast_fmt_pkg.sv
hdl/cast_op_pkg.sv
hdl/cast_pipe_stage.sv
hdl/cast_decode.sv
hdl/cast_shift_round.sv
hdl/cast_result_sel.sv
hdl/fp_int_cast.sv
dv/tb_fp_int_cast.sv

// ==== Bender.yml ====
package:
  name: fp_int_cast

sources:
  - files:
      - hdl/cast_fmt_pkg.sv
      - hdl/cast_op_pkg.sv
      - hdl/cast_pipe_stage.sv
      - hdl/cast_decode.sv
      - hdl/cast_shift_round.sv
      - hdl/cast_result_sel.sv
      - hdl/fp_int_cast.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_fp_int_cast.sv

// ==== dv/tb_cast_model.svh ====
// --------------------
// Stimulus generator
// --------------------
logic [31:0] rng_state = 32'he456_21f4;

function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  rng_state = x;
  return x;
endfunction

// IEEE increment decision from magnitude LSB, round bit and sticky bit
function automatic logic round_up(input cast_op_pkg::rnd_e rnd, input logic neg,
                                  input logic lsb, input logic rbit, input logic sbit);
  case (rnd)
    cast_op_pkg::RNE: return rbit && (sbit || lsb);  // Ties to even
    cast_op_pkg::RDN: return neg && (rbit || sbit);
    cast_op_pkg::RUP: return !neg && (rbit || sbit);
    cast_op_pkg::RMM: return rbit;                   // Ties away from zero
    default:          return 1'b0;                   // RTZ
  endcase
endfunction

// --------------------
// Half to integer
// --------------------
function automatic cast_op_pkg::rsp_t half_to_int(input logic [15:0] h, input logic uns,
                                                  input cast_op_pkg::rnd_e rnd);
  cast_op_pkg::rsp_t r;
  longint            sig;
  longint            mag;
  longint            rem;
  longint            half;
  int                scale;
  logic              rbit;
  logic              sbit;
  r    = '0;
  rbit = 1'b0;
  sbit = 1'b0;
  if (h[14:10] == 5'h1F) begin
    r.status.nv = 1'b1;
    if (h[9:0] != 0 || !h[15]) begin
      r.result = uns ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;  // NaN or +inf
    end else begin
      r.result = uns ? 32'h0 : 32'h8000_0000;          // -inf
    end
    return r;
  end
  // Value is sig * 2**scale exactly
  sig   = (h[14:10] == 0) ? h[9:0] : h[9:0] + 1024;
  scale = (h[14:10] == 0) ? -24 : int'(h[14:10]) - 25;
  if (scale >= 0) begin
    mag = sig <<< scale;
  end else begin
    mag  = sig >>> -scale;
    rem  = sig - (mag <<< -scale);  // Part below the integer LSB
    half = 64'sd1 <<< (-scale - 1);
    rbit = (rem >= half);
    sbit = (rem != 0) && (rem != half);
    if (round_up(rnd, h[15], mag[0], rbit, sbit)) mag++;
  end
  // Finite halves stay below 2**16 so no range saturation here
  if (uns && h[15] && mag != 0) begin
    r.status.nv = 1'b1;  // Negative into unsigned, result 0
  end else begin
    r.result    = h[15] ? -mag[31:0] : mag[31:0];
    r.status.nx = rbit | sbit;
  end
  return r;
endfunction

// --------------------
// Integer to half
// --------------------
function automatic cast_op_pkg::rsp_t int_to_half(input logic [31:0] op, input logic uns,
                                                  input cast_op_pkg::rnd_e rnd);
  cast_op_pkg::rsp_t r;
  logic              neg;
  logic [31:0]       mag;
  longint            sig;
  longint            rem;
  longint            half;
  int                msb;
  int                ex;
  logic              rbit;
  logic              sbit;
  logic              to_inf;
  r               = '0;
  r.result[31:16] = 16'hFFFF;  // NaN box
  rbit            = 1'b0;
  sbit            = 1'b0;
  msb             = 0;
  neg             = !uns && op[31];
  mag             = neg ? -op : op;
  if (mag == 0) return r;
  for (int i = 0; i < 32; i++) begin
    if (mag[i]) msb = i;
  end
  if (msb <= 10) begin
    sig = longint'(mag) << (10 - msb);  // Fits in 11 bits
  end else begin
    sig  = longint'(mag >> (msb - 10));
    rem  = longint'(mag) - (sig << (msb - 10));
    half = 64'sd1 << (msb - 11);
    rbit = (rem >= half);
    sbit = (rem != 0) && (rem != half);
  end
  if (round_up(rnd, neg, sig[0], rbit, sbit)) sig++;
  ex = msb + 15;
  if (sig == 2048) begin  // Carry into next binade
    sig = 1024;
    ex++;
  end
  r.status.nx = rbit | sbit;
  if (ex >= 31) begin
    // Overflow, inf or largest finite by mode
    to_inf = (rnd == cast_op_pkg::RNE) || (rnd == cast_op_pkg::RMM) ||
             (rnd == cast_op_pkg::RUP && !neg) || (rnd == cast_op_pkg::RDN && neg);
    r.result[15:0] = {neg, to_inf ? 15'h7C00 : 15'h7BFF};
    r.status.nv    = 1'b1;
    r.status.nx    = 1'b1;
  end else begin
    r.result[15:0] = {neg, ex[4:0], sig[9:0]};
  end
  return r;
endfunction

function automatic cast_op_pkg::rsp_t expected_rsp(input cast_op_pkg::req_t req);
  cast_op_pkg::rsp_t r;
  if (req.op == cast_op_pkg::F2I) begin
    r = half_to_int(req.operand[15:0], req.op_mod, req.rnd);
  end else begin
    r = int_to_half(req.operand, req.op_mod, req.rnd);
  end
  r.tag = req.tag;
  return r;
endfunction

// ==== dv/tb_fp_int_cast.sv ====
`timescale 1ns/1ps

module tb_fp_int_cast;

  localparam int N_EXACT  = 64;
  localparam int N_ROUND  = 200;
  localparam int N_RANGE  = 140;
  localparam int N_ZERO   = 70;
  localparam int N_BP     = 300;
  localparam int TIMEOUT_CYCLES = 20 * (N_EXACT + N_ROUND + N_RANGE + N_ZERO + N_BP) + 200;

  // NaNs, infinities, and negatives that saturate into unsigned
  localparam logic [15:0] RANGE_HALVES [8] = '{16'h7E00, 16'h7C01, 16'hFE00, 16'h7C00,
                                               16'hFC00, 16'hBC00, 16'hFBFF, 16'hB400};
  localparam logic [31:0] RANGE_INTS [6] = '{32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF,
                                             32'd65520, 32'd65535, 32'h0001_0000};

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic              in_ready;
  cast_op_pkg::req_t req;
  logic              out_valid;
  logic              out_ready;
  cast_op_pkg::rsp_t rsp;
  logic              busy;

  cast_op_pkg::req_t req_q[$];            // Waiting to be offered
  cast_op_pkg::rsp_t exp_q[$];            // Expected responses in issue order
  int                outstanding = 0;
  int                pass_count  = 0;
  int                err_count   = 0;
  int                cycle_count = 0;
  logic              req_taken   = 1'b0;  // Offer goes in on the coming rising edge
  logic              bp_mode     = 1'b0;  // Random out_ready
  logic [3:0]        next_tag    = '0;

  `include "tb_cast_model.svh"

  fp_int_cast i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .req_i       (req),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .rsp_o       (rsp),
    .busy_o      (busy)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Run timed out after %0d cycles with %0d responses missing",
             cycle_count, outstanding);
    $display("TB FAILED");
    $finish;
  end

  // --------------------
  // Driver and checker
  // --------------------
  initial begin : drive_inputs
    forever begin
      @(negedge clk);
      if (req_taken) in_valid = 1'b0;
      if (!in_valid && req_q.size() > 0) begin
        req      = req_q.pop_front();
        in_valid = 1'b1;
      end
      out_ready = bp_mode ? (next_rand() >= 32'h8000_0000) : 1'b1;
      #1;
      req_taken = in_valid && in_ready;
    end
  end

  initial begin : compare_responses
    cast_op_pkg::rsp_t exp_rsp;
    forever begin
      @(negedge clk);
      #1;  // Inputs settled, transfer decided for the next edge
      if (out_valid && out_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("Response with tag %0d arrived at %0t with none pending", rsp.tag, $time);
          err_count++;
        end
        if (exp_q.size() > 0) begin
          exp_rsp = exp_q.pop_front();
          outstanding--;
          assert (rsp === exp_rsp) pass_count++;
          else begin
            $display("Mismatch at %0t: tag %0d result %h status %b, expected tag %0d %h %b",
                     $time, rsp.tag, rsp.result, rsp.status,
                     exp_rsp.tag, exp_rsp.result, exp_rsp.status);
            err_count++;
          end
        end
      end
    end
  end

  task automatic queue_request(input logic [31:0] operand, input cast_op_pkg::op_e op,
                               input logic op_mod, input int rnd);
    cast_op_pkg::req_t r;
    r.operand = operand;
    r.op      = op;
    r.op_mod  = op_mod;
    r.rnd     = cast_op_pkg::rnd_e'(rnd);
    r.tag     = next_tag;
    next_tag++;
    req_q.push_back(r);
    exp_q.push_back(expected_rsp(r));
    outstanding++;
  endtask

  task automatic end_test(input string name, input int n, input int err_before);
    wait (outstanding == 0);
    @(negedge clk);  // Last transfer done, pipe empty
    assert (!busy) else begin
      $display("busy_o still high after the final response of test %s", name);
      err_count++;
    end
    $display("test %-8s %0d vectors, %0d errors", name, n, err_count - err_before);
    @(posedge clk);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin : run_tests
    int          err_before;
    logic [31:0] r;
    logic [15:0] h;
    logic [4:0]  e;
    logic        m;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    req       = '0;
    out_ready = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!busy && !out_valid) else begin
      $display("busy_o or out_valid_o high after reset");
      err_count++;
    end
    @(posedge clk);

    err_before = err_count;  // Small integers and integral halves
    for (int i = 0; i < N_EXACT / 2; i++) begin
      m = 1'(next_rand());
      r = next_rand() % 2049;
      if (!m && 1'(next_rand())) r = -r;
      queue_request(r, cast_op_pkg::I2F, m, next_rand() % 5);
      e = 15 + next_rand() % 11;
      h = {1'b0, e, 10'(next_rand()) & (10'h3FF << (25 - e))};  // Clear bits below 1
      if (!m) h[15] = 1'(next_rand());
      queue_request({16'hFFFF, h}, cast_op_pkg::F2I, m, next_rand() % 5);
    end
    end_test("exact", N_EXACT, err_before);

    err_before = err_count;
    for (int mode = 0; mode < 5; mode++) begin
      for (int i = 0; i < N_ROUND / 10; i++) begin
        m = 1'(next_rand());
        e = 1 + next_rand() % 24;                        // Always some fraction left
        h = {1'(next_rand()), e, 10'(next_rand()) | 10'h1};
        queue_request({16'hFFFF, h}, cast_op_pkg::F2I, m, mode);
        r = (next_rand() % 65536) | 32'h800;             // 12 to 16 significant bits
        if (!m && 1'(next_rand())) r = -r;
        queue_request(r, cast_op_pkg::I2F, m, mode);
      end
    end
    end_test("round", N_ROUND, err_before);

    err_before = err_count;
    for (int mode = 0; mode < 5; mode++) begin
      for (int k = 0; k < 2; k++) begin
        foreach (RANGE_HALVES[j]) begin
          queue_request({16'hFFFF, RANGE_HALVES[j]}, cast_op_pkg::F2I, k[0], mode);
        end
        foreach (RANGE_INTS[j]) begin
          queue_request(RANGE_INTS[j], cast_op_pkg::I2F, k[0], mode);
        end
      end
    end
    end_test("range", N_RANGE, err_before);

    err_before = err_count;
    for (int mode = 0; mode < 5; mode++) begin
      for (int k = 0; k < 2; k++) begin
        queue_request(32'hFFFF_0000, cast_op_pkg::F2I, k[0], mode);  // +0
        queue_request(32'hFFFF_8000, cast_op_pkg::F2I, k[0], mode);  // -0
        queue_request(32'h0, cast_op_pkg::I2F, k[0], mode);
        for (int i = 0; i < 4; i++) begin
          h = {1'(next_rand()), 5'h0, 10'(next_rand()) | 10'h1};
          queue_request({16'hFFFF, h}, cast_op_pkg::F2I, k[0], mode);
        end
      end
    end
    end_test("zero", N_ZERO, err_before);

    err_before = err_count;  // Random stalls on the response side
    bp_mode    = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      m = 1'(next_rand());
      r = next_rand();
      if (1'(next_rand())) begin
        queue_request(r, cast_op_pkg::I2F, m, next_rand() % 5);
      end else begin
        queue_request({16'hFFFF, r[15:0]}, cast_op_pkg::F2I, m, next_rand() % 5);
      end
    end
    end_test("stall", N_BP, err_before);
    bp_mode = 1'b0;

    $display("Checks passed %0d, failed %0d", pass_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/fp_int_cast.sv ====
`timescale 1ns/1ps

module fp_int_cast (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Request side
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  cast_op_pkg::req_t req_i,
  // Response side
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output cast_op_pkg::rsp_t rsp_o,
  output logic              busy_o  // Anything in flight
);

  cast_op_pkg::req_t                  req_q;
  logic                               req_valid;
  logic                               req_ready;
  cast_op_pkg::mid_t                  mid_d;
  cast_op_pkg::mid_t                  mid_q;
  logic                               mid_valid;
  logic                               mid_ready;
  cast_op_pkg::rsp_t                  rsp_d;
  logic [cast_fmt_pkg::INT_WIDTH-1:0] abs;
  logic                               sign;
  logic                               of_pre;
  logic                               of_post;
  logic                               uf_post;
  logic [1:0]                         sticky;

  // --------------------
  // Input register
  // --------------------
  cast_pipe_stage #(.payload_t(cast_op_pkg::req_t)) i_stage_in (
    .clk_i, .rst_n_i,
    .valid_i (in_valid_i), .ready_o (in_ready_o), .data_i (req_i),
    .valid_o (req_valid),  .ready_i (req_ready),  .data_o (req_q)
  );

  cast_decode i_decode (.req_i (req_q), .mid_o (mid_d));

  // --------------------
  // Middle register
  // --------------------
  cast_pipe_stage #(.payload_t(cast_op_pkg::mid_t)) i_stage_mid (
    .clk_i, .rst_n_i,
    .valid_i (req_valid), .ready_o (req_ready), .data_i (mid_d),
    .valid_o (mid_valid), .ready_i (mid_ready), .data_o (mid_q)
  );

  cast_shift_round i_shift_round (
    .mid_i (mid_q), .abs_o (abs), .sign_o (sign), .of_pre_o (of_pre),
    .of_post_o (of_post), .uf_post_o (uf_post), .sticky_o (sticky)
  );

  cast_result_sel i_result_sel (
    .mid_i (mid_q), .abs_i (abs), .sign_i (sign), .of_pre_i (of_pre),
    .of_post_i (of_post), .uf_post_i (uf_post), .sticky_i (sticky), .rsp_o (rsp_d)
  );

  // Output register drives the response port directly
  cast_pipe_stage #(.payload_t(cast_op_pkg::rsp_t)) i_stage_out (
    .clk_i, .rst_n_i,
    .valid_i (mid_valid),   .ready_o (mid_ready),   .data_i (rsp_d),
    .valid_o (out_valid_o), .ready_i (out_ready_i), .data_o (rsp_o)
  );

  assign busy_o = req_valid | mid_valid | out_valid_o;

endmodule

// ==== hdl/cast_result_sel.sv ====
`timescale 1ns/1ps

module cast_result_sel (
  input  cast_op_pkg::mid_t                  mid_i,
  input  logic [cast_fmt_pkg::INT_WIDTH-1:0] abs_i,
  input  logic                               sign_i,
  input  logic                               of_pre_i,
  input  logic                               of_post_i,
  input  logic                               uf_post_i,
  input  logic [1:0]                         sticky_i,
  output cast_op_pkg::rsp_t                  rsp_o
);

  logic                                dst_is_int;
  logic [cast_fmt_pkg::INT_WIDTH-1:0]  int_res;       // Two's complement after rounding
  logic                                int_res_zero;
  logic [cast_fmt_pkg::INT_WIDTH-1:0]  int_special;
  logic                                int_is_special;
  cast_op_pkg::status_t                int_status;
  logic [cast_fmt_pkg::INT_WIDTH-1:0]  int_result;
  logic [cast_fmt_pkg::FP_WIDTH-1:0]   fp_half;
  cast_op_pkg::status_t                fp_status;
  logic [cast_fmt_pkg::INT_WIDTH-1:0]  fp_result;

  assign dst_is_int = (mid_i.op == cast_op_pkg::F2I);

  // --------------------
  // F2I
  // --------------------
  assign int_res      = sign_i ? -abs_i : abs_i;
  assign int_res_zero = (int_res == '0);

  always_comb begin : int_saturate
    // Positive max: 0x7FFFFFFF signed, 0xFFFFFFFF unsigned
    int_special = {mid_i.op_mod, {(cast_fmt_pkg::INT_WIDTH-1){1'b1}}};
    if (sign_i && !mid_i.info.is_nan) begin
      int_special = ~int_special;  // Negative side, min or 0
    end
  end

  // NaN, inf, out of range, or a negative that survives rounding into unsigned
  assign int_is_special = mid_i.info.is_nan | mid_i.info.is_inf | of_pre_i |
                          (sign_i & mid_i.op_mod & ~int_res_zero);

  assign int_status = int_is_special ? '{nv: 1'b1, default: 1'b0}
                                     : '{nx: (|sticky_i), default: 1'b0};
  assign int_result = int_is_special ? int_special : int_res;

  // --------------------
  // I2F
  // --------------------
  // Integer zero would otherwise show the clamped exponent
  assign fp_half   = mid_i.mant_zero ? '0 : {sign_i, abs_i[cast_fmt_pkg::FP_WIDTH-2:0]};
  assign fp_result = {cast_fmt_pkg::BOX_ONES, fp_half};

  always_comb begin : fp_flags
    fp_status.nv = of_pre_i | of_post_i;  // Overflow reported as invalid
    fp_status.of = 1'b0;
    fp_status.nx = |sticky_i;
    fp_status.uf = uf_post_i & fp_status.nx;  // Tiny and inexact
  end

  // Result selection
  assign rsp_o.result = dst_is_int ? int_result : fp_result;
  assign rsp_o.status = dst_is_int ? int_status : fp_status;
  assign rsp_o.tag    = mid_i.tag;

endmodule

// ==== hdl/cast_shift_round.sv ====
`timescale 1ns/1ps

module cast_shift_round (
  input  cast_op_pkg::mid_t                  mid_i,
  output logic [cast_fmt_pkg::INT_WIDTH-1:0] abs_o,      // Rounded magnitude
  output logic                               sign_o,
  output logic                               of_pre_o,   // Out of range before rounding
  output logic                               of_post_o,  // Half exponent all ones
  output logic                               uf_post_o,  // Half exponent zero
  output logic [1:0]                         sticky_o    // Round and sticky bits
);

  logic                                 dst_is_int;
  cast_fmt_pkg::exp_t                   in_exp;
  cast_fmt_pkg::exp_t                   dest_exp;
  cast_fmt_pkg::exp_t                   final_exp;
  logic [2*cast_fmt_pkg::MAN_WIDTH:0]   preshift_mant;  // Mantissa left of the shifter
  logic [2*cast_fmt_pkg::MAN_WIDTH:0]   dest_mant;
  cast_fmt_pkg::shamt_t                 denorm_shamt;
  logic [cast_fmt_pkg::FP_MAN_BITS-1:0] final_mant;
  logic [cast_fmt_pkg::INT_WIDTH-1:0]   final_int;
  logic [1:0]                           fp_rs;
  logic [1:0]                           int_rs;
  logic [1:0]                           rs;
  logic [cast_fmt_pkg::INT_WIDTH-1:0]   pre_round_abs;
  logic                                 round_up;

  assign dst_is_int = (mid_i.op == cast_op_pkg::F2I);
  assign in_exp     = mid_i.in_exp;
  assign dest_exp   = mid_i.dest_exp;

  // --------------------
  // Range and shift
  // --------------------
  always_comb begin : cast_value
    final_exp     = dest_exp;
    preshift_mant = {mid_i.mant, {(cast_fmt_pkg::MAN_WIDTH+1){1'b0}}};
    denorm_shamt  = '0;
    of_pre_o      = 1'b0;
    if (dst_is_int) begin
      // Right shift so the integer LSB lands above the round bit
      denorm_shamt = cast_fmt_pkg::shamt_t'(cast_fmt_pkg::INT_WIDTH - 1 - in_exp);
      if (in_exp >= cast_fmt_pkg::INT_WIDTH - 1 + int'(mid_i.op_mod)) begin
        denorm_shamt = '0;  // Unsigned range is one bit wider
        of_pre_o     = 1'b1;
      end else if (in_exp < -1) begin
        denorm_shamt = cast_fmt_pkg::shamt_t'(cast_fmt_pkg::INT_WIDTH + 1);  // All to sticky
      end
    end else begin
      if (dest_exp >= (1 << cast_fmt_pkg::FP_EXP_BITS) - 1) begin
        // Largest finite with R and S set, rounding picks inf or max
        final_exp     = cast_fmt_pkg::exp_t'((1 << cast_fmt_pkg::FP_EXP_BITS) - 2);
        preshift_mant = '1;
        of_pre_o      = 1'b1;
      end else if (dest_exp < 1 && dest_exp >= -cast_fmt_pkg::FP_MAN_BITS) begin
        final_exp    = '0;  // Subnormal alignment
        denorm_shamt = cast_fmt_pkg::shamt_t'(1 - dest_exp);
      end else if (dest_exp < -cast_fmt_pkg::FP_MAN_BITS) begin
        final_exp    = '0;
        denorm_shamt = cast_fmt_pkg::shamt_t'(cast_fmt_pkg::FP_MAN_BITS + 2);
      end
    end
  end

  assign dest_mant = preshift_mant >> denorm_shamt;

  // Fraction and round bit, hidden bit dropped
  assign {final_mant, fp_rs[1]} =
      dest_mant[2*cast_fmt_pkg::MAN_WIDTH-1 -: cast_fmt_pkg::FP_MAN_BITS+1];
  assign {final_int, int_rs[1]} =
      dest_mant[2*cast_fmt_pkg::MAN_WIDTH -: cast_fmt_pkg::INT_WIDTH+1];
  // Collapse everything below the round bit
  assign fp_rs[0]  = |dest_mant[2*cast_fmt_pkg::MAN_WIDTH-cast_fmt_pkg::FP_MAN_BITS-2:0];
  assign int_rs[0] = |dest_mant[2*cast_fmt_pkg::MAN_WIDTH-cast_fmt_pkg::INT_WIDTH-1:0];

  assign rs = dst_is_int ? int_rs : fp_rs;

  assign pre_round_abs = dst_is_int ? final_int
      : {{(cast_fmt_pkg::INT_WIDTH-cast_fmt_pkg::FP_WIDTH+1){1'b0}},
         final_exp[cast_fmt_pkg::FP_EXP_BITS-1:0], final_mant};

  // --------------------
  // Rounding
  // --------------------
  always_comb begin : round_mode
    case (mid_i.rnd)
      cast_op_pkg::RNE: round_up = rs[1] & (rs[0] | pre_round_abs[0]);  // Ties to even
      cast_op_pkg::RTZ: round_up = 1'b0;
      cast_op_pkg::RDN: round_up = (|rs) & mid_i.sign;
      cast_op_pkg::RUP: round_up = (|rs) & ~mid_i.sign;
      cast_op_pkg::RMM: round_up = rs[1];                                // Ties away
      default:          round_up = 1'b0;
    endcase
  end

  // Carry out of the fraction bumps the exponent
  assign abs_o     = pre_round_abs + {{(cast_fmt_pkg::INT_WIDTH-1){1'b0}}, round_up};
  assign sign_o    = mid_i.sign;
  assign of_post_o = (abs_o[cast_fmt_pkg::FP_MAN_BITS +: cast_fmt_pkg::FP_EXP_BITS] == '1);
  assign uf_post_o = (abs_o[cast_fmt_pkg::FP_MAN_BITS +: cast_fmt_pkg::FP_EXP_BITS] == '0);
  assign sticky_o  = rs;

endmodule

// ==== hdl/cast_decode.sv ====
`timescale 1ns/1ps

module cast_decode (
  input  cast_op_pkg::req_t req_i,
  output cast_op_pkg::mid_t mid_o
);

  logic                                 src_is_int;
  logic                                 fp_sign;
  logic [cast_fmt_pkg::FP_EXP_BITS-1:0] fp_exp;
  logic [cast_fmt_pkg::FP_MAN_BITS-1:0] fp_man;
  cast_op_pkg::fp_info_t                info;
  logic                                 int_sign;
  cast_fmt_pkg::mant_t                  int_mant;   // Integer magnitude
  cast_fmt_pkg::mant_t                  enc_mant;   // Selected mantissa, LSB aligned
  cast_fmt_pkg::mant_t                  norm_mant;
  cast_fmt_pkg::lzc_t                   lzc;
  logic                                 mant_zero;
  cast_fmt_pkg::exp_t                   fp_in_exp;
  cast_fmt_pkg::exp_t                   int_in_exp;
  cast_fmt_pkg::exp_t                   in_exp;

  assign src_is_int = (req_i.op == cast_op_pkg::I2F);

  // --------------------
  // Half operand
  // --------------------
  assign fp_sign = req_i.operand[cast_fmt_pkg::FP_WIDTH-1];
  assign fp_exp  = req_i.operand[cast_fmt_pkg::FP_MAN_BITS +: cast_fmt_pkg::FP_EXP_BITS];
  assign fp_man  = req_i.operand[cast_fmt_pkg::FP_MAN_BITS-1:0];

  always_comb begin : classify
    info.is_zero      = (fp_exp == '0) && (fp_man == '0);
    info.is_subnormal = (fp_exp == '0) && (fp_man != '0);
    info.is_inf       = (fp_exp == '1) && (fp_man == '0);
    info.is_nan       = (fp_exp == '1) && (fp_man != '0);
    // Quiet bit clear means signalling
    info.is_signalling = info.is_nan &&
        ((fp_man & cast_fmt_pkg::QNAN_HALF[cast_fmt_pkg::FP_MAN_BITS-1:0]) == '0);
  end

  // --------------------
  // Integer operand
  // --------------------
  assign int_sign = req_i.operand[cast_fmt_pkg::INT_WIDTH-1] & ~req_i.op_mod;  // Unsigned never negative
  assign int_mant = int_sign ? -req_i.operand : req_i.operand;

  // Hidden bit set for any nonzero exponent field
  assign enc_mant = src_is_int ? int_mant
      : {{(cast_fmt_pkg::MAN_WIDTH-cast_fmt_pkg::FP_MAN_BITS-1){1'b0}}, (fp_exp != '0), fp_man};

  // Leading-zero count, highest set bit wins
  always_comb begin : lzc_count
    lzc = '1;  // Zero counts as full width so its exponent lands at 0
    for (int i = 0; i < cast_fmt_pkg::MAN_WIDTH; i++) begin
      if (enc_mant[i]) lzc = cast_fmt_pkg::lzc_t'(cast_fmt_pkg::MAN_WIDTH - 1 - i);
    end
  end

  assign mant_zero = (enc_mant == '0);
  assign norm_mant = enc_mant << lzc;

  // Unbias, then undo the shift and the padding above the fraction
  assign fp_in_exp = cast_fmt_pkg::exp_t'(int'(fp_exp) + int'(info.is_subnormal)
      - cast_fmt_pkg::FP_BIAS - int'(lzc)
      + (cast_fmt_pkg::MAN_WIDTH - 1 - cast_fmt_pkg::FP_MAN_BITS));
  assign int_in_exp = cast_fmt_pkg::exp_t'(cast_fmt_pkg::MAN_WIDTH - 1 - int'(lzc));
  assign in_exp     = src_is_int ? int_in_exp : fp_in_exp;

  always_comb begin : pack_mid
    mid_o.sign      = src_is_int ? int_sign : fp_sign;
    mid_o.in_exp    = in_exp;
    mid_o.mant      = norm_mant;
    mid_o.dest_exp  = in_exp + cast_fmt_pkg::exp_t'(cast_fmt_pkg::FP_BIAS);  // Rebias
    mid_o.op        = req_i.op;
    mid_o.op_mod    = req_i.op_mod;
    mid_o.rnd       = req_i.rnd;
    mid_o.info      = src_is_int ? '0 : info;  // Classification only means something for F2I
    mid_o.mant_zero = mant_zero;
    mid_o.tag       = req_i.tag;
  end

  // LZC and shifter must agree, otherwise the exponent is off
  a_norm_msb: assert final ($isunknown(req_i) || mant_zero ||
                            norm_mant[cast_fmt_pkg::MAN_WIDTH-1]);

endmodule

// ==== hdl/cast_pipe_stage.sv ====
`timescale 1ns/1ps

module cast_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;  // Loaded on transfer only

  // Accept when downstream takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // Bubble in if nothing offered
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Upstream must hold a stalled offer until this stage takes it
  a_hold_offer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && !ready_o) |=> (valid_i && $stable(data_i)));

endmodule

// ==== hdl/cast_op_pkg.sv ====
package cast_op_pkg;

  // Direction of the conversion
  typedef enum logic {
    F2I = 1'b0,  // half -> int
    I2F = 1'b1   // int -> half
  } op_e;

  // IEEE rounding modes, RISC-V encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } rnd_e;

  typedef struct packed {
    logic nv;  // Invalid
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  typedef logic [3:0] tag_t;

  // Half operand classification
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // --------------------
  // Stage payloads
  // --------------------
  typedef struct packed {
    logic [cast_fmt_pkg::INT_WIDTH-1:0] operand;  // Half in bits 15:0 for F2I
    op_e                                op;
    logic                               op_mod;   // Unsigned integer
    rnd_e                               rnd;
    tag_t                               tag;
  } req_t;

  typedef struct packed {
    logic                sign;
    cast_fmt_pkg::exp_t  in_exp;    // Unbiased
    cast_fmt_pkg::mant_t mant;      // Normalized, MSB is the leading one
    cast_fmt_pkg::exp_t  dest_exp;  // Rebiased for binary16
    op_e                 op;
    logic                op_mod;
    rnd_e                rnd;
    fp_info_t            info;
    logic                mant_zero;
    tag_t                tag;
  } mid_t;

  typedef struct packed {
    logic [cast_fmt_pkg::INT_WIDTH-1:0] result;
    status_t                            status;
    tag_t                               tag;
  } rsp_t;

endpackage

// ==== hdl/cast_fmt_pkg.sv ====
package cast_fmt_pkg;

  // --------------------
  // binary16 geometry
  // --------------------
  localparam int FP_WIDTH    = 16;
  localparam int FP_EXP_BITS = 5;
  localparam int FP_MAN_BITS = 10;  // Stored fraction, hidden bit not counted
  localparam int FP_BIAS     = 15;  // 2**(FP_EXP_BITS-1) - 1

  // Integer side, signed or unsigned by op_mod
  localparam int INT_WIDTH = 32;

  // --------------------
  // Internal datapath
  // --------------------
  // Mantissa holds hidden bit plus fraction, or a whole integer
  localparam int MAN_WIDTH   = 32;
  localparam int EXP_WIDTH   = 8;   // Signed, unbiased input exponent plus rebias
  localparam int LZC_WIDTH   = 5;   // Leading-zero count over MAN_WIDTH
  localparam int SHAMT_WIDTH = 6;   // Denormalizing shift, up to MAN_WIDTH+1

  // Special encodings
  localparam logic [FP_WIDTH-1:0] QNAN_HALF = 16'h7E00;       // Canonical quiet NaN
  localparam logic [INT_WIDTH-FP_WIDTH-1:0] BOX_ONES = '1;    // NaN-box fill, bits 31:16

  // Datapath word types
  typedef logic signed [EXP_WIDTH-1:0] exp_t;
  typedef logic [MAN_WIDTH-1:0]        mant_t;
  typedef logic [LZC_WIDTH-1:0]        lzc_t;
  typedef logic [SHAMT_WIDTH-1:0]      shamt_t;

endpackage
